// File: files.f
+incdir+src
+incdir+test
src/tag_store_pkg.sv
src/tag_req_decode.sv
src/tag_way_array.sv
src/tag_result.sv
src/tag_store_top.sv
test/tag_store_chk.sv
test/tag_store_tb.sv

// File: run.sh
#!/bin/sh
# Build the tag store testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tag_store_tb \
  -f files.f --Mdir obj_dir -o tag_store_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tag_store_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: src/tag_req_decode.sv
// ***********************************************************
// Tag store request control
// Sweeps all sets clear after reset, then accepts one request
// at a time, holds it as the active request and strobes the
// tag RAM read one cycle after acceptance
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tag_store_cfg.svh"

module tag_req_decode
  import tag_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  input  tag_req_t req_i,
  output logic     ready_o,
  input  logic     res_take_i,
  output tag_req_t act_req_o,
  output logic     rd_en_o,
  output index_t   rd_index_o,
  output logic     clr_en_o,
  output index_t   clr_index_o
);

  // Clear sweep, waiting for a request, request in flight
  typedef enum logic [1:0] {
    ST_CLEAR = 2'd0,
    ST_IDLE  = 2'd1,
    ST_BUSY  = 2'd2
  } dec_state_e;

  dec_state_e state_q;
  index_t     clr_cnt_q;
  tag_req_t   act_req_q;
  logic       rd_en_q;
  logic       accept;

  // Only idle takes a new request
  // Busy holds until the result stage consumes the read
  assign ready_o = (state_q == ST_IDLE);
  assign accept  = valid_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_CLEAR;
      clr_cnt_q <= '0;
      rd_en_q   <= 1'b0;
    end else begin
      // Read strobe follows acceptance by one cycle
      rd_en_q <= accept;
      unique case (state_q)
        ST_CLEAR: begin
          // One set per cycle, all ways at once
          clr_cnt_q <= clr_cnt_q + index_t'(1);
          if (clr_cnt_q == index_t'(`TAG_SETS - 1)) begin
            state_q <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          // Back to idle once the response is built
          if (res_take_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Active request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      act_req_q <= req_i;
    end
  end

  assign act_req_o   = act_req_q;
  assign rd_en_o     = rd_en_q;
  // Read address comes straight from the held request
  assign rd_index_o  = act_req_q.index;
  assign clr_en_o    = (state_q == ST_CLEAR);
  assign clr_index_o = clr_cnt_q;

endmodule

`default_nettype wire

// File: src/tag_result.sv
// ***********************************************************
// Tag result stage
// Picks the victim way on a miss, builds the response,
// keeps it in the output register and issues the single
// write-back into the tag RAMs when the result is taken
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tag_store_cfg.svh"

module tag_result
  import tag_store_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  tag_req_t   act_req_i,
  input  way_read_t  rd_data_i,
  input  logic       rd_valid_i,
  output logic       res_take_o,
  output ram_write_t wr_cmd_o,
  output tag_res_t   res_o,
  output logic       valid_o,
  input  logic       ready_i
);

  localparam int unsigned WayIdxW = $clog2(`TAG_WAYS);

  typedef logic [WayIdxW-1:0] way_idx_t;

  // First set bit of ways at or after start with wrap-around
  function automatic way_idx_t first_way(input way_vec_t ways, input way_idx_t start);
    way_idx_t cand;
    logic     found;
    first_way = start;
    found     = 1'b0;
    for (int unsigned k = 0; k < `TAG_WAYS; k++) begin
      cand = start + way_idx_t'(k);
      if (!found && ways[cand]) begin
        first_way = cand;
        found     = 1'b1;
      end
    end
  endfunction

  way_idx_t   rr_ptr_q;
  way_vec_t   free_ways;
  way_idx_t   victim_idx;
  way_vec_t   victim_way;
  logic       is_hit;
  logic       rr_used;
  way_idx_t   sel_idx;
  tag_entry_t sel_entry;
  logic       sel_evict;
  tag_res_t   res_next;
  tag_res_t   res_q;
  logic       valid_q;
  ram_write_t wr_next;

  // Invalid enabled ways are filled first with the lowest way winning
  assign free_ways  = act_req_i.indicator & ~rd_data_i.valid;
  assign rr_used    = ~(|free_ways);
  assign victim_idx = rr_used ? first_way(act_req_i.indicator, rr_ptr_q) :
                                first_way(free_ways, '0);
  assign victim_way = (|act_req_i.indicator) ? (way_vec_t'(1) << victim_idx) : '0;
  assign is_hit     = |rd_data_i.hit;

  // Entry that the response reports on
  always_comb begin
    if (act_req_i.mode == FLUSH) begin
      sel_idx = first_way(act_req_i.indicator, '0);
    end else if (is_hit) begin
      sel_idx = first_way(rd_data_i.hit, '0);
    end else begin
      sel_idx = victim_idx;
    end
  end
  assign sel_entry = rd_data_i.entry[sel_idx];
  // Selected line must be written out when valid and dirty
  assign sel_evict = rd_data_i.valid[sel_idx] & rd_data_i.dirty[sel_idx];

  // Response and write-back for the active request
  always_comb begin
    res_next  = '0;
    wr_next   = '0;
    wr_next.index = act_req_i.index;
    if (act_req_i.mode == FLUSH) begin
      res_next.indicator = act_req_i.indicator;
      res_next.evict     = sel_evict;
      res_next.evict_tag = sel_evict ? sel_entry.tag : '0;
      // Zero entry written back over the flushed line
      wr_next.way_en     = act_req_i.indicator;
    end else if (is_hit) begin
      res_next.indicator = rd_data_i.hit;
      res_next.hit       = 1'b1;
      // Only a clean line hit by a dirty request needs the write
      wr_next.way_en     = (act_req_i.dirty && !sel_entry.dirty) ? rd_data_i.hit : '0;
      wr_next.entry      = '{valid: 1'b1, dirty: 1'b1, tag: act_req_i.tag};
    end else begin
      res_next.indicator = victim_way;
      res_next.evict     = sel_evict;
      res_next.evict_tag = sel_evict ? sel_entry.tag : '0;
      wr_next.way_en     = victim_way;
      wr_next.entry      = '{valid: 1'b1, dirty: act_req_i.dirty, tag: act_req_i.tag};
    end
  end

  // Take the read once the output register has room
  assign res_take_o = rd_valid_i & (~valid_q | ready_i);

  assign wr_cmd_o = '{
    way_en: res_take_o ? wr_next.way_en : '0,
    index:  wr_next.index,
    entry:  wr_next.entry
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= 1'b0;
      rr_ptr_q <= '0;
    end else begin
      if (res_take_o) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
      // Pointer moves only on a round-robin eviction
      if (res_take_o && act_req_i.mode == LOOKUP && !is_hit && rr_used &&
          |act_req_i.indicator) begin
        rr_ptr_q <= victim_idx + way_idx_t'(1);
      end
    end
  end

  // Output register payload
  always_ff @(posedge clk_i) begin
    if (res_take_o) begin
      res_q <= res_next;
    end
  end

  assign res_o   = res_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: src/tag_store_cfg.svh
// ***********************************************************
// Tag store configuration
// Geometry of the last-level cache tag store: way count,
// set count, set index width and stored tag width
// ***********************************************************

`ifndef TAG_STORE_CFG_SVH
`define TAG_STORE_CFG_SVH

// Number of ways, one tag RAM each
`define TAG_WAYS 4

// Number of sets, the depth of every tag RAM
`define TAG_SETS 16

// Width of the set index, log2 of the set count
`define TAG_INDEX_W 4

// Width of the stored tag
`define TAG_W 8

`endif

// File: src/tag_store_pkg.sv
// ***********************************************************
// Tag store package
// Request, response, stored entry, read bundle and
// write-back command types shared by the tag store blocks
// ***********************************************************

`default_nettype none

`include "tag_store_cfg.svh"

package tag_store_pkg;

  // One bit per way
  typedef logic [`TAG_WAYS-1:0] way_vec_t;
  typedef logic [`TAG_INDEX_W-1:0] index_t;
  typedef logic [`TAG_W-1:0] tag_t;

  // Word held in each tag RAM line
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic {
    LOOKUP = 1'b0,
    FLUSH  = 1'b1
  } tag_mode_e;

  // Indicator holds the enabled ways on Lookup
  // and exactly one way on Flush
  typedef struct packed {
    tag_mode_e mode;
    index_t    index;
    tag_t      tag;
    logic      dirty;
    way_vec_t  indicator;
  } tag_req_t;

  // Indicator is the one-hot way that hit, was chosen or was flushed
  typedef struct packed {
    way_vec_t indicator;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

  // Everything the result stage needs from one RAM read
  typedef struct packed {
    way_vec_t                  hit;
    way_vec_t                  valid;
    way_vec_t                  dirty;
    tag_entry_t [`TAG_WAYS-1:0] entry;
  } way_read_t;

  // Single write-back into the tag RAMs
  typedef struct packed {
    way_vec_t   way_en;
    index_t     index;
    tag_entry_t entry;
  } ram_write_t;

endpackage

`default_nettype wire

// File: src/tag_store_top.sv
// ***********************************************************
// Tag store top level
// Request control, tag way array and result stage of the
// last-level cache tag store with Lookup and Flush
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module tag_store_top
  import tag_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  input  tag_req_t req_i,
  output logic     ready_o,
  output tag_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  tag_req_t   act_req;
  logic       rd_en;
  index_t     rd_index;
  logic       clr_en;
  index_t     clr_index;
  way_read_t  rd_data;
  logic       rd_valid;
  ram_write_t wr_cmd;
  logic       res_take;

  // Accepts requests and drives the RAM read
  tag_req_decode u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .req_i       (req_i),
    .ready_o     (ready_o),
    .res_take_i  (res_take),
    .act_req_o   (act_req),
    .rd_en_o     (rd_en),
    .rd_index_o  (rd_index),
    .clr_en_o    (clr_en),
    .clr_index_o (clr_index)
  );

  // Tag RAMs and compare
  tag_way_array u_execute (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .act_req_i   (act_req),
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .clr_en_i    (clr_en),
    .clr_index_i (clr_index),
    .wr_cmd_i    (wr_cmd),
    .res_take_i  (res_take),
    .rd_data_o   (rd_data),
    .rd_valid_o  (rd_valid)
  );

  // Victim choice, response register and write-back
  tag_result u_result (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .act_req_i  (act_req),
    .rd_data_i  (rd_data),
    .rd_valid_i (rd_valid),
    .res_take_o (res_take),
    .wr_cmd_o   (wr_cmd),
    .res_o      (res_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i)
  );

endmodule

`default_nettype wire

// File: src/tag_way_array.sv
// ***********************************************************
// Tag way array
// One single-port tag RAM per way with one cycle read
// latency, per-way tag compare and the read bundle with
// its valid level for the result stage
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tag_store_cfg.svh"

module tag_way_array
  import tag_store_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  tag_req_t   act_req_i,
  input  logic       rd_en_i,
  input  index_t     rd_index_i,
  input  logic       clr_en_i,
  input  index_t     clr_index_i,
  input  ram_write_t wr_cmd_i,
  input  logic       res_take_i,
  output way_read_t  rd_data_o,
  output logic       rd_valid_o
);

  way_vec_t                   way_hit;
  way_vec_t                   way_valid;
  way_vec_t                   way_dirty;
  tag_entry_t [`TAG_WAYS-1:0] way_entry;
  logic                       rd_valid_q;

  for (genvar w = 0; w < `TAG_WAYS; w++) begin : gen_way
    tag_entry_t mem_q [`TAG_SETS];
    tag_entry_t rdata_q;

    // Single port, so clear beats write and write beats read
    always_ff @(posedge clk_i) begin
      if (clr_en_i) begin
        mem_q[clr_index_i] <= '0;
      end else if (wr_cmd_i.way_en[w]) begin
        mem_q[wr_cmd_i.index] <= wr_cmd_i.entry;
      end else if (rd_en_i && act_req_i.indicator[w]) begin
        // Disabled ways are not read at all
        rdata_q <= mem_q[rd_index_i];
      end
    end

    // Hit needs the way enabled, valid and a matching tag
    assign way_hit[w]   = act_req_i.indicator[w] & rdata_q.valid &
                          (rdata_q.tag == act_req_i.tag);
    assign way_valid[w] = rdata_q.valid;
    assign way_dirty[w] = rdata_q.dirty;
    assign way_entry[w] = rdata_q;
  end

  // Read data valid level
  // Set after each read, dropped when the result is taken
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      rd_valid_q <= 1'b1;
    end else if (res_take_i) begin
      rd_valid_q <= 1'b0;
    end
  end

  assign rd_data_o = '{
    hit:   way_hit,
    valid: way_valid,
    dirty: way_dirty,
    entry: way_entry
  };
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

// File: test/tag_store_chk.sv
// ***********************************************************
// Tag store protocol checker
// Concurrent assertions on the response hold rule, the
// one-hot way indicator and single request acceptance
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module tag_store_chk
  import tag_store_pkg::*;
(
  input logic     clk_i,
  input logic     reset_i,
  input logic     valid_i,
  input logic     ready_o,
  input tag_res_t res_o,
  input logic     valid_o,
  input logic     ready_i
);

  // Stalled response keeps valid and payload
  hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && (res_o == $past(res_o)))
    else $error("response dropped or changed while stalled");

  // Exactly one way reported
  onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o |-> $onehot(res_o.indicator))
    else $error("response way indicator is not one-hot");

  // An accepted request blocks the port next cycle
  single_a: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i && ready_o |=> !ready_o)
    else $error("request port still ready right after an acceptance");

endmodule

bind tag_store_top tag_store_chk u_chk (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .valid_i (valid_i),
  .ready_o (ready_o),
  .res_o   (res_o),
  .valid_o (valid_o),
  .ready_i (ready_i)
);

`default_nettype wire

// File: test/tag_store_model.svh
// ***********************************************************
// Tag store reference model
// Mirrors every tag entry and the shared round-robin
// pointer, predicts each response in request order and
// updates its own state as the store would
// ***********************************************************

`ifndef TAG_STORE_MODEL_SVH
`define TAG_STORE_MODEL_SVH

  // Entries per way and set, plus the victim pointer
  tag_entry_t  store_mem [`TAG_WAYS][`TAG_SETS];
  int unsigned rr_ptr;

  // State right after the clear sweep
  function automatic void clear_model();
    for (int w = 0; w < `TAG_WAYS; w++) begin
      for (int s = 0; s < `TAG_SETS; s++) begin
        store_mem[w][s] = '0;
      end
    end
    rr_ptr = 0;
  endfunction

  // Way holding a valid copy of the tag, enabled or not
  function automatic int holding_way(input index_t idx, input tag_t tag);
    int way;
    way = -1;
    for (int w = 0; w < `TAG_WAYS; w++) begin
      if (store_mem[w][idx].valid && store_mem[w][idx].tag == tag) begin
        way = w;
      end
    end
    return way;
  endfunction

  function automatic tag_res_t predict_res(input tag_req_t req);
    tag_res_t   res;
    tag_entry_t old;
    int         way;
    int         slot;
    res = '0;
    old = '0;
    way = -1;
    if (req.mode == FLUSH) begin
      for (int w = 0; w < `TAG_WAYS; w++) begin
        if (req.indicator[w]) begin
          way = w;
        end
      end
      old = store_mem[way][req.index];
      store_mem[way][req.index] = '0;
      res.indicator = req.indicator;
    end else begin
      way = holding_way(req.index, req.tag);
      if (way >= 0 && req.indicator[way]) begin
        // Hit, a dirty request marks the line dirty
        res.indicator = way_vec_t'(1) << way;
        res.hit       = 1'b1;
        store_mem[way][req.index].dirty = store_mem[way][req.index].dirty | req.dirty;
      end else begin
        way = -1;
        // Lowest enabled invalid way first
        for (int w = `TAG_WAYS - 1; w >= 0; w--) begin
          if (req.indicator[w] && !store_mem[w][req.index].valid) begin
            way = w;
          end
        end
        // Set full, so first enabled way from the pointer on
        if (way < 0) begin
          for (int k = `TAG_WAYS - 1; k >= 0; k--) begin
            slot = (rr_ptr + k) % `TAG_WAYS;
            if (req.indicator[slot]) begin
              way = slot;
            end
          end
          rr_ptr = (way + 1) % `TAG_WAYS;
        end
        old = store_mem[way][req.index];
        store_mem[way][req.index] = '{valid: 1'b1, dirty: req.dirty, tag: req.tag};
        res.indicator = way_vec_t'(1) << way;
      end
    end
    // Evict only a valid dirty line, tag zero otherwise
    if (old.valid && old.dirty) begin
      res.evict     = 1'b1;
      res.evict_tag = old.tag;
    end
    return res;
  endfunction

`endif

// File: test/tag_store_tb.sv
// ***********************************************************
// Tag store testbench
// Directed Lookup and Flush sequences, then random traffic
// under response back-pressure, with every response
// compared in order against the reference model
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "tag_store_cfg.svh"

module tag_store_tb
  import tag_store_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_RAND     = 200;
  // Directed tests send 64, 3, 6 and 2 requests
  localparam int NUM_REQ      = 75 + NUM_RAND;
  localparam int WATCHDOG_CYC = NUM_REQ * 20;

  logic     clk_i = 1'b0;
  logic     reset_i;
  logic     valid_i;
  tag_req_t req_i;
  logic     ready_o;
  tag_res_t res_o;
  logic     valid_o;
  logic     ready_i;

  logic     bp_en;
  int       cyc;
  int       rise_cyc;
  int       err_cnt;
  int       resp_cnt;
  int       err_base;
  int       resp_base;
  tag_res_t exp_res;
  tag_res_t exp_q[$];

  `include "tag_store_model.svh"

  tag_store_top u_dut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .req_i   (req_i),
    .ready_o (ready_o),
    .res_o   (res_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Cycle count and random response back-pressure
  always @(posedge clk_i) begin
    cyc     <= cyc + 1;
    ready_i <= bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // Sampled half a cycle after the drive edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      // Empty output register, so valid_o rises two cycles after acceptance
      if (cyc == rise_cyc - 1 || cyc == rise_cyc) begin
        assert (valid_o == (cyc == rise_cyc)) else begin
          $display("FAILED valid_o expected %h got %h at cycle %0d",
                   cyc == rise_cyc, valid_o, cyc);
          err_cnt++;
        end
      end
      if (valid_i && ready_o && !valid_o) begin
        rise_cyc = cyc + 3;
      end
      // Response transfers on the coming edge
      if (valid_o && ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("response arrived with no request outstanding");
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          exp_res = exp_q.pop_front();
          assert (res_o == exp_res) else begin
            $display("FAILED res_o expected %h got %h", exp_res, res_o);
            err_cnt++;
          end
        end
        resp_cnt++;
      end
    end
  end

  function automatic tag_req_t make_req(input tag_mode_e mode, input int idx, input int tag,
                                        input logic dirty, input way_vec_t ind);
    tag_req_t r;
    r.mode      = mode;
    r.index     = index_t'(idx);
    r.tag       = tag_t'(tag);
    r.dirty     = dirty;
    r.indicator = ind;
    return r;
  endfunction

  // Few sets and tags so hits and conflicts are frequent
  function automatic tag_req_t rand_req();
    tag_req_t r;
    int       w;
    r       = '0;
    r.index = index_t'($urandom_range(0, 2));
    r.tag   = tag_t'($urandom_range(1, 6));
    r.dirty = 1'($urandom_range(0, 1));
    if ($urandom_range(0, 4) == 0) begin
      r.mode      = FLUSH;
      r.indicator = way_vec_t'(1) << $urandom_range(0, `TAG_WAYS - 1);
    end else begin
      r.mode      = LOOKUP;
      r.indicator = way_vec_t'($urandom_range(1, (1 << `TAG_WAYS) - 1));
      // Way that already holds the tag stays enabled, no duplicate copies
      w = holding_way(r.index, r.tag);
      if (w >= 0) begin
        r.indicator[w] = 1'b1;
      end
    end
    return r;
  endfunction

  // Predict, then hold the request until the DUT takes it
  task automatic send(input tag_req_t req);
    exp_q.push_back(predict_res(req));
    @(posedge clk_i);
    valid_i <= 1'b1;
    req_i   <= req;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  task automatic finish_test(input int num, input string name);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    $display("test %0d %s: %0d responses, %0d errors", num, name,
             resp_cnt - resp_base, err_cnt - err_base);
    resp_base = resp_cnt;
    err_base  = err_cnt;
  endtask

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, %0d responses outstanding",
             WATCHDOG_CYC, exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h49660996));
    reset_i   = 1'b1;
    valid_i   = 1'b0;
    req_i     = '0;
    ready_i   = 1'b1;
    bp_en     = 1'b0;
    cyc       = 0;
    rise_cyc  = -10;
    err_cnt   = 0;
    resp_cnt  = 0;
    err_base  = 0;
    resp_base = 0;
    clear_model();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    // Clear sweep ends when ready_o rises
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end

    for (int s = 0; s < `TAG_SETS; s++) begin
      for (int w = 0; w < `TAG_WAYS; w++) begin
        send(make_req(LOOKUP, s, 'h40 + 4 * s + w, 1'b0, '1));
      end
    end
    finish_test(1, "lookup fill");

    send(make_req(LOOKUP, 0, 'h40, 1'b0, '1));
    send(make_req(LOOKUP, 0, 'h40, 1'b1, '1));
    send(make_req(FLUSH, 0, 0, 1'b0, 4'b0001));
    finish_test(2, "hit and dirty flush");

    // Dirty ways 1 and 3, then four misses on the full set
    send(make_req(LOOKUP, 1, 'h45, 1'b1, '1));
    send(make_req(LOOKUP, 1, 'h47, 1'b1, '1));
    for (int k = 0; k < `TAG_WAYS; k++) begin
      send(make_req(LOOKUP, 1, 'h80 + k, 1'b0, '1));
    end
    finish_test(3, "round robin eviction");

    send(make_req(FLUSH, 1, 0, 1'b0, 4'b0100));
    send(make_req(LOOKUP, 1, 'h82, 1'b1, '1));
    finish_test(4, "flush then refill");

    bp_en = 1'b1;
    repeat (NUM_RAND) send(rand_req());
    finish_test(5, "random traffic");
    bp_en = 1'b0;

    $display("all tests done: %0d responses checked, %0d errors", resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
